// File: tb.f
+incdir+logic
+incdir+bench
logic/sar_pkg.sv
logic/sar_reg_decode.sv
logic/sar_convert.sv
logic/sar_result.sv
logic/sar_adc_top.sv
bench/tb_sar_adc.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the sar adc testbench with verilator, exit status 1 on any failure

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_sar_adc -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_sar_adc > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
exit 0

// File: bench/tb_sar_tasks.svh
// bus access, reference conversion and typed compare tasks, included inside the sar adc testbench
`ifndef TB_SAR_TASKS_SVH
`define TB_SAR_TASKS_SVH

////////////////////////////////////////
// typed compares
////////////////////////////////////////

task automatic check_code(input string name, input adc_code_t exp, input adc_code_t act);
    if (act !== exp) begin
        $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
        val_errs++;
    end
endtask

task automatic check_word(input string name, input logic [`SAR_WB_DW-1:0] exp,
                          input logic [`SAR_WB_DW-1:0] act);
    if (act !== exp) begin
        $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
        val_errs++;
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("FAIL %0t %s expected %b got %b", $time, name, exp, act);
        val_errs++;
    end
endtask

////////////////////////////////////////
// reference model of one conversion
////////////////////////////////////////

// halve the level, then keep the bit only when the residue is strictly above it
function automatic adc_code_t expected_code(input logic [`SAR_VIN_W-1:0] v,
                                            input logic [`SAR_VIN_W-1:0] r);
    logic [`SAR_VIN_W-1:0] res;
    logic [`SAR_VIN_W-1:0] lvl;
    adc_code_t             c;
    res = v;
    lvl = r;
    c   = '0;
    for (int i = `SAR_ADC_BITS - 1; i >= 0; i--) begin
        lvl = lvl >> 1;
        if (res > lvl) begin
            c[i] = 1'b1;
            res  = res - lvl;   // what is left for the lower bits
        end
    end
    return c;
endfunction

////////////////////////////////////////
// wishbone classic master
////////////////////////////////////////

// one single access, drive at +2 ns, sample at +1 ns after the edge
task automatic bus_access(input logic wr, input logic [`SAR_WB_AW-1:0] a,
                          input logic [`SAR_WB_DW-1:0] wd, output logic [`SAR_WB_DW-1:0] rd);
    int waited;
    @(posedge clk);
    #2;
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = wr;
    adr   = a;
    dat_w = wd;
    waited = 0;
    do begin
        @(posedge clk);
        #1;
        waited++;
    end while (!ack && waited < 8);
    if (!ack) begin
        $display("bus access to address %0d was never acknowledged", a);
        other_errs++;
    end
    rd = dat_r;   // valid while ack is high
    #1;
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
    n_access++;
    @(posedge clk);
    #1;
    check_bit("ack", 1'b0, ack);   // single-cycle ack
endtask

task automatic wb_write(input logic [`SAR_WB_AW-1:0] a, input logic [`SAR_WB_DW-1:0] d);
    logic [`SAR_WB_DW-1:0] unused_rd;
    bus_access(1'b1, a, d, unused_rd);
endtask

task automatic wb_read(input logic [`SAR_WB_AW-1:0] a, output logic [`SAR_WB_DW-1:0] d);
    bus_access(1'b0, a, '0, d);
endtask

`endif

// File: bench/tb_sar_adc.sv
// directed testbench for the four-channel sar adc peripheral and the top module of the simulation
`timescale 1ns/100ps
`default_nettype none

`include "sar_defs.svh"

module tb_sar_adc;
    import sar_pkg::*;

    localparam int CYCLE_LIMIT = 6 * 40 * 20 + 1000;   // tests x conversions x cycles + margin

    logic                  clk, rst_n, cyc, stb, we, ack, done;
    logic [`SAR_WB_AW-1:0] adr;
    logic [`SAR_WB_DW-1:0] dat_w, dat_r;
    logic [`SAR_VIN_W-1:0] vin [`SAR_CHANNELS];
    logic [`SAR_VIN_W-1:0] vref;

    int val_errs = 0;     // wrong values
    int other_errs = 0;   // missing handshakes
    int n_access = 0;
    int ack_count = 0;
    int done_count = 0;
    int starts_ok = 0;    // accepted starts
    int cycles = 0;
    int seed;

    // expected state of the peripheral
    adc_code_t                exp_codes [`SAR_CHANNELS];
    logic [`SAR_CHANNELS-1:0] over_model;
    adc_code_t                thr_model;

    sar_adc_top i_dut (
        .clk, .rst_n, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack,
        .vin0(vin[0]), .vin1(vin[1]), .vin2(vin[2]), .vin3(vin[3]),
        .vref, .done
    );

    `include "tb_sar_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;   // 40 ns period
    end

    // pulse counters and run limit
    always @(posedge clk) begin
        cycles++;
        if (rst_n && ack)
            ack_count++;
        if (rst_n && done)
            done_count++;
        if (cycles > CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles, a test hung", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////
    // conversion helpers
    ////////////////////////////////////////

    task automatic start_conv(input chan_t ch, input logic [`SAR_VIN_W-1:0] v,
                              input logic [`SAR_VIN_W-1:0] r);
        @(posedge clk);
        #2;
        vin[ch] = v;
        vref    = r;
        wb_write(`SAR_WB_AW'(`SAR_ADDR_CMD), `SAR_WB_DW'({ch, 1'b1}));   // chan + start
        starts_ok++;
        exp_codes[ch]  = expected_code(v, r);
        over_model[ch] = exp_codes[ch] > thr_model;
    endtask

    task automatic wait_done(input int target);
        int n;
        n = 0;
        while (done_count < target && n < 40) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (done_count < target) begin
            $display("conversion did not finish, no done pulse seen");
            other_errs++;
        end
    endtask

    // all result registers and status against the model
    task automatic check_all();
        logic [`SAR_WB_DW-1:0] rd;
        for (int i = 0; i < `SAR_CHANNELS; i++) begin
            wb_read(`SAR_WB_AW'(`SAR_ADDR_RESULT0 + i), rd);
            check_code($sformatf("result%0d", i), exp_codes[i], adc_code_t'(rd));
        end
        wb_read(`SAR_WB_AW'(`SAR_ADDR_STATUS), rd);
        check_word("status", `SAR_WB_DW'(over_model) << 4, rd);
    endtask

    task automatic convert(input chan_t ch, input logic [`SAR_VIN_W-1:0] v,
                           input logic [`SAR_VIN_W-1:0] r);
        start_conv(ch, v, r);
        wait_done(starts_ok);
        check_all();
    endtask

    task automatic set_threshold(input adc_code_t t);
        logic [`SAR_WB_DW-1:0] rd;
        wb_write(`SAR_WB_AW'(`SAR_ADDR_THRESH), {22'h2A5A5, t});   // junk in reserved bits
        thr_model = t;
        wb_read(`SAR_WB_AW'(`SAR_ADDR_THRESH), rd);
        check_word("threshold", `SAR_WB_DW'(t), rd);
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////

    task automatic test_reset_values();
        logic [`SAR_WB_DW-1:0] rd;
        for (int a = 0; a < 8; a++) begin
            wb_read(`SAR_WB_AW'(a), rd);
            check_word($sformatf("reg%0d", a), '0, rd);
        end
        check_word("ack count", n_access, ack_count);
    endtask

    task automatic test_fixed_inputs();
        convert(0, 16'h0000, 16'hFFFF);
        convert(1, 16'hFFFF, 16'hFFFF);
        convert(2, 16'h8000, 16'hFFFF);   // just above the first level
        convert(3, 16'h7FFF, 16'hFFFF);   // equal to it so msb stays 0
        convert(0, 16'h0001, 16'hFFFF);
    endtask

    task automatic test_random();
        logic [`SAR_VIN_W-1:0] v, r;
        chan_t                 ch;
        repeat (20) begin
            v  = $random(seed);
            r  = $random(seed);
            ch = chan_t'($random(seed));
            convert(ch, v, r);
        end
    endtask

    task automatic test_threshold();
        set_threshold(10'h100);
        convert(2, 16'hC000, 16'hFFFF);   // above so the flag sets
        set_threshold(exp_codes[2]);
        convert(2, 16'hC000, 16'hFFFF);   // equal so the flag clears
        set_threshold(10'h000);
        convert(1, 16'h4000, 16'hFFFF);
        set_threshold(10'h3FF);
        convert(1, 16'h4000, 16'hFFFF);   // below
    endtask

    task automatic test_overrun();
        logic [`SAR_WB_DW-1:0] rd;
        start_conv(0, 16'h5555, 16'hFFFF);
        wb_read(`SAR_WB_AW'(`SAR_ADDR_STATUS), rd);
        check_bit("busy", 1'b1, rd[0]);      // conversion still running
        check_bit("overrun", 1'b0, rd[1]);
        @(posedge clk);
        #2;
        vin[1] = 16'h1234;
        wb_write(`SAR_WB_AW'(`SAR_ADDR_CMD), `SAR_WB_DW'({2'd1, 1'b1}));   // refused
        wait_done(starts_ok);
        wb_read(`SAR_WB_AW'(`SAR_ADDR_STATUS), rd);
        check_bit("overrun", 1'b1, rd[1]);
        check_bit("busy", 1'b0, rd[0]);
        wb_read(`SAR_WB_AW'(`SAR_ADDR_STATUS), rd);
        check_bit("overrun", 1'b0, rd[1]);   // cleared by the read before
        check_all();                         // channel 1 untouched
    endtask

    task automatic test_done_pulses();
        convert(3, 16'h2222, 16'h8000);
        convert(3, 16'h0100, 16'h0400);
        repeat (3) @(posedge clk);
        #1;
        check_word("done pulses", starts_ok, done_count);
        check_word("ack count", n_access, ack_count);
    endtask

    initial begin
        rst_n = 1'b0;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        dat_w = '0;
        vref  = '0;
        foreach (vin[i])
            vin[i] = '0;
        foreach (exp_codes[i])
            exp_codes[i] = '0;
        over_model = '0;
        thr_model  = '0;
        seed       = 4311;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        test_reset_values();
        test_fixed_inputs();
        test_random();
        test_threshold();
        test_overrun();
        test_done_pulses();

        $display("errors: %0d value, %0d other", val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/sar_adc_top.sv
// top of the four-channel sar adc peripheral, wishbone slave plus analog-code inputs
`timescale 1ns/100ps
`default_nettype none

`include "sar_defs.svh"

module sar_adc_top (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  cyc,
    input  wire logic                  stb,
    input  wire logic                  we,
    input  wire logic [`SAR_WB_AW-1:0] adr,
    input  wire logic [`SAR_WB_DW-1:0] dat_w,
    output logic      [`SAR_WB_DW-1:0] dat_r,
    output logic                       ack,
    input  wire logic [`SAR_VIN_W-1:0] vin0,
    input  wire logic [`SAR_VIN_W-1:0] vin1,
    input  wire logic [`SAR_VIN_W-1:0] vin2,
    input  wire logic [`SAR_VIN_W-1:0] vin3,
    input  wire logic [`SAR_VIN_W-1:0] vref,
    output logic                       done
);
    import sar_pkg::*;

    ////////////////////////////////////////
    // stage wiring
    ////////////////////////////////////////

    logic                     start_req, busy;
    chan_t                    start_chan;
    logic                     conv_valid;
    adc_code_t                conv_code;
    chan_t                    conv_chan;
    adc_code_t                threshold;
    logic                     overrun_set, status_rd, overrun;
    adc_code_t                result_code0, result_code1, result_code2, result_code3;
    logic [`SAR_CHANNELS-1:0] over_flags;

    // decode
    sar_reg_decode i_decode (
        .clk, .rst_n, .cyc, .stb, .we, .adr, .dat_w, .busy,
        .result_code0, .result_code1, .result_code2, .result_code3,
        .over_flags, .overrun, .dat_r, .ack,
        .start_req, .start_chan, .threshold, .overrun_set, .status_rd
    );

    // execute
    sar_convert i_convert (
        .clk, .rst_n, .start_req, .start_chan,
        .vin0, .vin1, .vin2, .vin3, .vref,
        .busy, .conv_valid, .conv_code, .conv_chan
    );

    // result
    sar_result i_result (
        .clk, .rst_n, .conv_valid, .conv_code, .conv_chan,
        .threshold, .overrun_set, .status_rd,
        .result_code0, .result_code1, .result_code2, .result_code3,
        .over_flags, .overrun, .done
    );

endmodule

`default_nettype wire

// File: logic/sar_result.sv
// result stage of the sar adc, stores codes per channel and keeps the sticky status flags
`timescale 1ns/100ps
`default_nettype none

`include "sar_defs.svh"

module sar_result (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  conv_valid,   // code from convert
    input  wire sar_pkg::adc_code_t    conv_code,
    input  wire sar_pkg::chan_t        conv_chan,
    input  wire sar_pkg::adc_code_t    threshold,
    input  wire logic                  overrun_set,  // refused start
    input  wire logic                  status_rd,    // clears overrun
    output sar_pkg::adc_code_t         result_code0,
    output sar_pkg::adc_code_t         result_code1,
    output sar_pkg::adc_code_t         result_code2,
    output sar_pkg::adc_code_t         result_code3,
    output logic [`SAR_CHANNELS-1:0]   over_flags,
    output logic                       overrun,
    output logic                       done          // one pulse per stored code
);
    import sar_pkg::*;

    adc_code_t codes [`SAR_CHANNELS];
    logic      over_now;

    // compare against the live threshold at store time
    assign over_now = conv_code > threshold;

    ////////////////////////////////////////
    // code store and over flags
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `SAR_CHANNELS; i++) begin
                codes[i] <= '0;
            end
            over_flags <= '0;
            done       <= 1'b0;
        end else begin
            done <= conv_valid;
            if (conv_valid) begin
                codes[conv_chan]      <= conv_code;
                over_flags[conv_chan] <= over_now;   // equal or below clears
            end
        end
    end

    // overrun is sticky until status is read
    always_ff @(posedge clk) begin
        if (!rst_n)
            overrun <= 1'b0;
        else if (overrun_set)
            overrun <= 1'b1;   // set beats a clear in the same cycle
        else if (status_rd)
            overrun <= 1'b0;
    end

    assign result_code0 = codes[0];
    assign result_code1 = codes[1];
    assign result_code2 = codes[2];
    assign result_code3 = codes[3];

endmodule

`default_nettype wire

// File: logic/sar_convert.sv
// successive-approximation engine, samples one channel and resolves one bit per clock
`timescale 1ns/100ps
`default_nettype none

`include "sar_defs.svh"

module sar_convert (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  start_req,   // one-cycle start from decode
    input  wire sar_pkg::chan_t        start_chan,
    input  wire logic [`SAR_VIN_W-1:0] vin0,
    input  wire logic [`SAR_VIN_W-1:0] vin1,
    input  wire logic [`SAR_VIN_W-1:0] vin2,
    input  wire logic [`SAR_VIN_W-1:0] vin3,
    input  wire logic [`SAR_VIN_W-1:0] vref,        // full scale
    output logic                       busy,
    output logic                       conv_valid,  // one cycle, code ready
    output sar_pkg::adc_code_t         conv_code,
    output sar_pkg::chan_t             conv_chan
);
    import sar_pkg::*;

    localparam int IDX_W = $clog2(`SAR_ADC_BITS);

    logic [IDX_W-1:0]      bit_idx;      // bit being resolved, msb first
    logic [`SAR_VIN_W-1:0] vin_sel;
    logic [`SAR_VIN_W-1:0] residue;      // input left to resolve
    logic [`SAR_VIN_W-1:0] trial;        // dac level, halves each step
    logic [`SAR_VIN_W-1:0] trial_half;
    logic [`SAR_VIN_W-1:0] residue_nxt;
    logic                  step_bit;
    logic                  take;         // start accepted this cycle
    adc_code_t             code;
    chan_t                 chan;

    assign take = start_req & ~busy;

    always_comb begin
        case (start_chan)
            2'd0:    vin_sel = vin0;
            2'd1:    vin_sel = vin1;
            2'd2:    vin_sel = vin2;
            default: vin_sel = vin3;
        endcase
    end

    ////////////////////////////////////////
    // one approximation step
    ////////////////////////////////////////

    assign trial_half  = trial >> 1;                 // halve first, then compare
    assign step_bit    = residue > trial_half;       // strictly greater
    assign residue_nxt = step_bit ? residue - trial_half : residue;

    // sequencing, 1 sample cycle then SAR_ADC_BITS bit cycles
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            conv_valid <= 1'b0;
            bit_idx    <= '0;
        end else begin
            conv_valid <= 1'b0;
            if (take) begin
                busy    <= 1'b1;
                bit_idx <= IDX_W'(`SAR_ADC_BITS - 1);
            end else if (busy) begin
                if (bit_idx == '0) begin
                    busy       <= 1'b0;         // lsb resolved
                    conv_valid <= 1'b1;
                end else begin
                    bit_idx <= bit_idx - 1'b1;
                end
            end
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (take) begin
            residue <= vin_sel;       // sample the selected input
            trial   <= vref;
            chan    <= start_chan;
            code    <= '0;
        end else if (busy) begin
            code[bit_idx] <= step_bit;
            residue       <= residue_nxt;
            trial         <= trial_half;
        end
    end

    assign conv_code = code;
    assign conv_chan = chan;

endmodule

`default_nettype wire

// File: logic/sar_reg_decode.sv
// wishbone classic register slave for the sar adc, issues start requests and serves reads
`timescale 1ns/100ps
`default_nettype none

`include "sar_defs.svh"

module sar_reg_decode (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   cyc,
    input  wire logic                   stb,
    input  wire logic                   we,
    input  wire logic [`SAR_WB_AW-1:0]  adr,
    input  wire logic [`SAR_WB_DW-1:0]  dat_w,
    input  wire logic                   busy,         // conversion running
    input  wire sar_pkg::adc_code_t     result_code0,
    input  wire sar_pkg::adc_code_t     result_code1,
    input  wire sar_pkg::adc_code_t     result_code2,
    input  wire sar_pkg::adc_code_t     result_code3,
    input  wire logic [`SAR_CHANNELS-1:0] over_flags,
    input  wire logic                   overrun,
    output logic [`SAR_WB_DW-1:0]       dat_r,
    output logic                        ack,
    output logic                        start_req,    // one-cycle pulse to convert
    output sar_pkg::chan_t              start_chan,
    output sar_pkg::adc_code_t          threshold,
    output logic                        overrun_set,  // refused start
    output logic                        status_rd     // acked status read
);
    import sar_pkg::*;

    wb_wdata_u             wr_word;   // dat_w seen as cmd or thresh
    adc_code_t             results [`SAR_CHANNELS];
    logic                  req;       // new access this cycle
    logic                  hit_cmd, hit_thresh, hit_status, hit_result;
    logic [`SAR_WB_DW-1:0] rd_word;
    logic [`SAR_WB_DW-1:0] status_word;

    assign wr_word = dat_w;
    assign results[0] = result_code0;
    assign results[1] = result_code1;
    assign results[2] = result_code2;
    assign results[3] = result_code3;

    // ack is high for one cycle, so a held stb is not taken twice
    assign req = cyc & stb & ~ack;

    assign hit_cmd    = (adr == `SAR_WB_AW'(`SAR_ADDR_CMD));
    assign hit_thresh = (adr == `SAR_WB_AW'(`SAR_ADDR_THRESH));
    assign hit_status = (adr == `SAR_WB_AW'(`SAR_ADDR_STATUS));
    assign hit_result = (adr >= `SAR_WB_AW'(`SAR_ADDR_RESULT0)) &&
                        (adr <  `SAR_WB_AW'(`SAR_ADDR_RESULT0 + `SAR_CHANNELS));

    ////////////////////////////////////////
    // read mux
    ////////////////////////////////////////

    always_comb begin
        status_word = '0;
        status_word[0] = busy;
        status_word[1] = overrun;
        status_word[4 +: `SAR_CHANNELS] = over_flags;   // bits 7:4

        rd_word = '0;                                   // unmapped and CMD read zero
        if (hit_status)
            rd_word = status_word;
        else if (hit_thresh)
            rd_word = `SAR_WB_DW'(threshold);
        else if (hit_result)
            rd_word = `SAR_WB_DW'(results[chan_t'(adr - `SAR_WB_AW'(`SAR_ADDR_RESULT0))]);
    end

    ////////////////////////////////////////
    // bus handshake and control pulses
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack         <= 1'b0;
            start_req   <= 1'b0;
            overrun_set <= 1'b0;
            status_rd   <= 1'b0;
            threshold   <= '0;
        end else begin
            ack         <= req;
            // pulses line up with ack
            start_req   <= req & we & hit_cmd & wr_word.cmd.start & ~busy;
            overrun_set <= req & we & hit_cmd & wr_word.cmd.start & busy;
            status_rd   <= req & ~we & hit_status;
            if (req && we && hit_thresh)
                threshold <= wr_word.thresh.code;
        end
    end

    // data and channel only matter while ack / start_req are high
    always_ff @(posedge clk) begin
        if (req) begin
            dat_r      <= rd_word;
            start_chan <= wr_word.cmd.chan;
        end
    end

endmodule

`default_nettype wire

// File: logic/sar_pkg.sv
// types shared by the sar adc stages and the testbench, import where a code or channel is used
`default_nettype none

`include "sar_defs.svh"

package sar_pkg;

    // one converted sample
    typedef logic [`SAR_ADC_BITS-1:0] adc_code_t;

    // channel index
    typedef logic [$clog2(`SAR_CHANNELS)-1:0] chan_t;

    ////////////////////////////////////////
    // bus write word views
    ////////////////////////////////////////

    // CMD register layout
    typedef struct packed {
        logic [`SAR_WB_DW-2-$bits(chan_t):0] rsvd;   // ignored
        chan_t                               chan;   // bits 2:1
        logic                                start;  // bit 0
    } cmd_view_t;

    // THRESH register layout
    typedef struct packed {
        logic [`SAR_WB_DW-`SAR_ADC_BITS-1:0] rsvd;   // ignored
        adc_code_t                           code;   // bits 9:0
    } thresh_view_t;

    // same 32 bits, picked apart by address in the decode stage
    typedef union packed {
        cmd_view_t    cmd;
        thresh_view_t thresh;
    } wb_wdata_u;

endpackage

`default_nettype wire

// File: logic/sar_defs.svh
// shared sizes and register map for the sar adc peripheral, include wherever a width is needed
`ifndef SAR_DEFS_SVH
`define SAR_DEFS_SVH

////////////////////////////////////////
// converter sizing
////////////////////////////////////////

`define SAR_ADC_BITS 10     // resolution, one bit per step
`define SAR_CHANNELS 4      // analog inputs vin0..vin3
`define SAR_VIN_W    16     // width of an input or vref code

////////////////////////////////////////
// wishbone slave sizing
////////////////////////////////////////

`define SAR_WB_DW 32        // data width
`define SAR_WB_AW 4         // word address width

////////////////////////////////////////
// register map, word addresses
////////////////////////////////////////

`define SAR_ADDR_CMD     0  // start bit + channel, write only
`define SAR_ADDR_THRESH  1  // over-threshold level
`define SAR_ADDR_STATUS  2  // busy, overrun, over flags

// result codes, one word per channel from here up
`define SAR_ADDR_RESULT0 4

`endif
